// ==== hdl/glay_pkg.sv ====
/*
 Shared widths and the memory word layout for the graph kernel.
 Every design file imports this package in its module header.
*/
package glay_pkg;

  // ------------------------------------------------------------
  // Bus widths
  // ------------------------------------------------------------
  localparam int addr_width = 32;
  localparam int data_width = 64;
  localparam int vid_width  = 32;

  // Each half of a memory word
  localparam int half_width = data_width / 2;

  // ------------------------------------------------------------
  // Memory word, decoded as list header or as edge
  // ------------------------------------------------------------
  // Result word reuses the edge layout: count high, weight sum low
  typedef union packed {
    struct packed {
      logic [half_width-1:0] reserved;
      logic [half_width-1:0] num_edges;
    } header;
    struct packed {
      logic [vid_width-1:0]            dst_id;
      logic [data_width-vid_width-1:0] weight;
    } edge_rec;
  } mem_word_u;

endpackage

// ==== hdl/mem_read_if.sv ====
/*
 Word read port between the edge reader and the response register slice.
 Request and response channels are both valid/ready.
*/
interface mem_read_if import glay_pkg::*; ();

  // Request channel
  logic                  req_valid;
  logic                  req_ready;
  logic [addr_width-1:0] req_addr;

  // Response channel, returns in request order
  logic                  rsp_valid;
  logic                  rsp_ready;
  logic [data_width-1:0] rsp_data;

  modport requester (
    output req_valid, req_addr, rsp_ready,
    input  req_ready, rsp_valid, rsp_data
  );

  modport memory (
    input  req_valid, req_addr, rsp_ready,
    output req_ready, rsp_valid, rsp_data
  );

endinterface

// ==== hdl/kernel_control.sv ====
/*
 Host handshake in ap_ctrl_hs form, stretched core reset and descriptor capture.
 Sits between the host control ports and the datapath of kernel_afu.
*/
module kernel_control import glay_pkg::*; #(
  parameter int PULSE_HOLD = 16
) (
  input  logic                  ap_clk,
  input  logic                  ap_rst_n,
  input  logic                  ap_start,
  input  logic [addr_width-1:0] buffer_0,
  input  logic [vid_width-1:0]  buffer_1,
  input  logic [addr_width-1:0] buffer_2,
  input  logic                  wr_done,
  output logic                  ap_idle,
  output logic                  ap_done,
  output logic                  ap_ready,
  output logic                  core_rst,
  output logic                  start,
  output logic [addr_width-1:0] base_addr,
  output logic [vid_width-1:0]  target_vid,
  output logic [addr_width-1:0] result_addr
);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_busy = 2'd1;
  localparam logic [1:0] st_done = 2'd2;

  logic [1:0]            state;
  logic [PULSE_HOLD-1:0] hold_sr;

  // ------------------------------------------------------------
  // Reset stretcher
  // ------------------------------------------------------------
  // Reloaded on reset and on every completion, then drains to zero
  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      hold_sr <= '1;
    end else if (ap_done) begin
      hold_sr <= '1;
    end else begin
      hold_sr <= hold_sr << 1;
    end
  end

  assign core_rst = hold_sr[PULSE_HOLD-1];

  // ------------------------------------------------------------
  // Run FSM and descriptor capture
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      state       <= st_idle;
      start       <= 1'b0;
      base_addr   <= '0;
      target_vid  <= '0;
      result_addr <= '0;
    end else begin
      start <= 1'b0;
      case (state)
        st_idle: begin
          // Accept only once the datapath is out of reset
          if (ap_start && !core_rst) begin
            state       <= st_busy;
            start       <= 1'b1;
            base_addr   <= buffer_0;
            target_vid  <= buffer_1;
            result_addr <= buffer_2;
          end
        end
        st_busy: begin
          if (wr_done) begin
            state <= st_done;
          end
        end
        // One cycle for the done/ready pulse
        default: state <= st_idle;
      endcase
    end
  end

  assign ap_idle  = (state != st_busy);
  assign ap_done  = (state == st_done);
  assign ap_ready = (state == st_done);

endmodule

// ==== hdl/read_register_slice.sv ====
/*
 Register slice between the edge reader and the memory read port.
 Requests pass as wires; responses go through a two-entry skid buffer.
*/
module read_register_slice import glay_pkg::*; (
  input  logic                  ap_clk,
  input  logic                  ap_rst_n,
  input  logic                  core_rst,
  mem_read_if.memory            core,
  output logic                  mem_rd_req_valid,
  input  logic                  mem_rd_req_ready,
  output logic [addr_width-1:0] mem_rd_req_addr,
  input  logic                  mem_rd_rsp_valid,
  output logic                  mem_rd_rsp_ready,
  input  logic [data_width-1:0] mem_rd_rsp_data
);

  logic [data_width-1:0] slot [2];
  logic                  wr_ptr;
  logic                  rd_ptr;
  logic [1:0]            fill;
  logic                  push;
  logic                  pop;

  // Request channel untouched
  assign mem_rd_req_valid = core.req_valid;
  assign mem_rd_req_addr  = core.req_addr;
  assign core.req_ready   = mem_rd_req_ready;

  // ------------------------------------------------------------
  // Response skid buffer
  // ------------------------------------------------------------
  // Ready from fill level only, no path from core.rsp_ready
  assign mem_rd_rsp_ready = (fill != 2'd2);
  assign push             = mem_rd_rsp_valid && mem_rd_rsp_ready;
  assign pop              = core.rsp_valid && core.rsp_ready;
  assign core.rsp_valid   = (fill != 2'd0);
  assign core.rsp_data    = slot[rd_ptr];

  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      wr_ptr  <= 1'b0;
      rd_ptr  <= 1'b0;
      fill    <= 2'd0;
      slot[0] <= '0;
      slot[1] <= '0;
    end else if (core_rst) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      fill   <= 2'd0;
    end else begin
      if (push) begin
        slot[wr_ptr] <= mem_rd_rsp_data;
        wr_ptr       <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      // Simultaneous push and pop keeps the level
      if (push && !pop) begin
        fill <= fill + 2'd1;
      end else if (pop && !push) begin
        fill <= fill - 2'd1;
      end
    end
  end

endmodule

// ==== hdl/edge_reader.sv ====
/*
 Fetches the edge list header, then streams the edge words that follow it.
 Edge requests are pipelined and never wait on responses.
*/
module edge_reader import glay_pkg::*; (
  input  logic                  ap_clk,
  input  logic                  ap_rst_n,
  input  logic                  core_rst,
  input  logic                  start,
  input  logic [addr_width-1:0] base_addr,
  mem_read_if.requester         rd,
  output logic                  edge_valid,
  output mem_word_u             edge_word,
  output logic                  list_done
);

  localparam logic [1:0] st_idle     = 2'd0;
  localparam logic [1:0] st_hdr_req  = 2'd1;
  localparam logic [1:0] st_hdr_wait = 2'd2;
  localparam logic [1:0] st_edges    = 2'd3;

  logic [1:0]            state;
  logic                  req_valid;
  logic [addr_width-1:0] req_addr;
  logic [half_width-1:0] to_issue;
  logic [half_width-1:0] to_recv;
  logic                  req_fire;
  logic                  rsp_fire;
  mem_word_u             rsp_word;

  assign rsp_word     = rd.rsp_data;
  assign rd.req_valid = req_valid;
  assign rd.req_addr  = req_addr;
  // No response can be owed before the header request is accepted
  assign rd.rsp_ready = (state == st_hdr_wait) || (state == st_edges);
  assign req_fire     = req_valid && rd.req_ready;
  assign rsp_fire     = rd.rsp_valid && rd.rsp_ready;

  // Edge stream straight from the accepted response
  assign edge_valid = rsp_fire && (state == st_edges);
  assign edge_word  = rsp_word;

  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      state     <= st_idle;
      req_valid <= 1'b0;
      req_addr  <= '0;
      to_issue  <= '0;
      to_recv   <= '0;
      list_done <= 1'b0;
    end else if (core_rst) begin
      state     <= st_idle;
      req_valid <= 1'b0;
      to_issue  <= '0;
      to_recv   <= '0;
      list_done <= 1'b0;
    end else begin
      list_done <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin
            state     <= st_hdr_req;
            req_valid <= 1'b1;
            req_addr  <= base_addr;
          end
        end
        st_hdr_req: begin
          if (req_fire) begin
            req_valid <= 1'b0;
            state     <= st_hdr_wait;
          end
        end
        st_hdr_wait: begin
          if (rsp_fire) begin
            to_issue <= rsp_word.header.num_edges;
            to_recv  <= rsp_word.header.num_edges;
            // Empty list ends right after the header
            if (rsp_word.header.num_edges == '0) begin
              list_done <= 1'b1;
              state     <= st_idle;
            end else begin
              req_valid <= 1'b1;
              req_addr  <= req_addr + 1'b1;
              state     <= st_edges;
            end
          end
        end
        default: begin
          // Issue side
          if (req_fire) begin
            to_issue <= to_issue - 1'b1;
            req_addr <= req_addr + 1'b1;
            if (to_issue == 1) begin
              req_valid <= 1'b0;
            end
          end
          // Response side, last one closes the list
          if (rsp_fire) begin
            to_recv <= to_recv - 1'b1;
            if (to_recv == 1) begin
              list_done <= 1'b1;
              state     <= st_idle;
            end
          end
        end
      endcase
    end
  end

endmodule

// ==== hdl/vertex_reduce.sv ====
/*
 Reduction stage: counts edges into the target vertex and sums their weights.
 Produces the result word one cycle after the edge list ends.
*/
module vertex_reduce import glay_pkg::*; (
  input  logic                 ap_clk,
  input  logic                 ap_rst_n,
  input  logic                 core_rst,
  input  logic                 start,
  input  logic [vid_width-1:0] target_vid,
  input  logic                 edge_valid,
  input  mem_word_u            edge_word,
  input  logic                 list_done,
  output logic                 sum_valid,
  output mem_word_u            result_word
);

  logic [vid_width-1:0]            match_cnt;
  logic [data_width-vid_width-1:0] weight_sum;
  logic                            hit;

  assign hit = edge_valid && (edge_word.edge_rec.dst_id == target_vid);

  // ------------------------------------------------------------
  // Accumulators, wrap modulo 2^32
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      match_cnt  <= '0;
      weight_sum <= '0;
      sum_valid  <= 1'b0;
    end else if (core_rst || start) begin
      match_cnt  <= '0;
      weight_sum <= '0;
      sum_valid  <= 1'b0;
    end else begin
      if (hit) begin
        match_cnt  <= match_cnt + 1'b1;
        weight_sum <= weight_sum + edge_word.edge_rec.weight;
      end
      sum_valid <= list_done;
    end
  end

  // Count in the upper half, sum in the lower
  always_comb begin
    result_word.edge_rec.dst_id = match_cnt;
    result_word.edge_rec.weight = weight_sum;
  end

endmodule

// ==== hdl/result_writer.sv ====
/*
 Writes the single result word and waits for the memory acknowledge.
 wr_done tells the control FSM that the run is complete.
*/
module result_writer import glay_pkg::*; (
  input  logic                  ap_clk,
  input  logic                  ap_rst_n,
  input  logic                  core_rst,
  input  logic                  sum_valid,
  input  mem_word_u             result_word,
  input  logic [addr_width-1:0] result_addr,
  input  logic                  mem_wr_ready,
  input  logic                  mem_wr_ack,
  output logic                  mem_wr_valid,
  output logic [addr_width-1:0] mem_wr_addr,
  output logic [data_width-1:0] mem_wr_data,
  output logic                  wr_done
);

  logic ack_wait;

  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      mem_wr_valid <= 1'b0;
      mem_wr_addr  <= '0;
      mem_wr_data  <= '0;
      ack_wait     <= 1'b0;
      wr_done      <= 1'b0;
    end else if (core_rst) begin
      mem_wr_valid <= 1'b0;
      ack_wait     <= 1'b0;
      wr_done      <= 1'b0;
    end else begin
      wr_done <= 1'b0;
      // Load the write, held until accepted
      if (sum_valid) begin
        mem_wr_valid <= 1'b1;
        mem_wr_addr  <= result_addr;
        mem_wr_data  <= result_word;
      end else if (mem_wr_valid && mem_wr_ready) begin
        mem_wr_valid <= 1'b0;
        ack_wait     <= 1'b1;
      end
      // Ack pulse comes some cycles after the transfer
      if (ack_wait && mem_wr_ack) begin
        ack_wait <= 1'b0;
        wr_done  <= 1'b1;
      end
    end
  end

endmodule

// ==== hdl/kernel_afu.sv ====
/*
 Graph kernel top level: control block and edge datapath on plain ports.
 Host sets buffer_0..2 and pulses ap_start; one word goes to buffer_2.
*/
module kernel_afu import glay_pkg::*; #(
  parameter int PULSE_HOLD = 16
) (
  input  logic                  ap_clk,
  input  logic                  ap_rst_n,
  // Host control
  input  logic                  ap_start,
  output logic                  ap_idle,
  output logic                  ap_done,
  output logic                  ap_ready,
  input  logic [addr_width-1:0] buffer_0,
  input  logic [vid_width-1:0]  buffer_1,
  input  logic [addr_width-1:0] buffer_2,
  // Memory read port
  output logic                  mem_rd_req_valid,
  input  logic                  mem_rd_req_ready,
  output logic [addr_width-1:0] mem_rd_req_addr,
  input  logic                  mem_rd_rsp_valid,
  output logic                  mem_rd_rsp_ready,
  input  logic [data_width-1:0] mem_rd_rsp_data,
  // Memory write port
  output logic                  mem_wr_valid,
  input  logic                  mem_wr_ready,
  output logic [addr_width-1:0] mem_wr_addr,
  output logic [data_width-1:0] mem_wr_data,
  input  logic                  mem_wr_ack
);

  // ------------------------------------------------------------
  // Internal wires
  // ------------------------------------------------------------
  logic                  core_rst;
  logic                  start;
  logic [addr_width-1:0] base_addr;
  logic [vid_width-1:0]  target_vid;
  logic [addr_width-1:0] result_addr;
  logic                  edge_valid;
  mem_word_u             edge_word;
  logic                  list_done;
  logic                  sum_valid;
  mem_word_u             result_word;
  logic                  wr_done;

  mem_read_if rd_core ();

  kernel_control #(
    .PULSE_HOLD (PULSE_HOLD)
  ) u_kernel_control (
    .ap_clk      (ap_clk),
    .ap_rst_n    (ap_rst_n),
    .ap_start    (ap_start),
    .buffer_0    (buffer_0),
    .buffer_1    (buffer_1),
    .buffer_2    (buffer_2),
    .wr_done     (wr_done),
    .ap_idle     (ap_idle),
    .ap_done     (ap_done),
    .ap_ready    (ap_ready),
    .core_rst    (core_rst),
    .start       (start),
    .base_addr   (base_addr),
    .target_vid  (target_vid),
    .result_addr (result_addr)
  );

  // ------------------------------------------------------------
  // Read path: edge reader, then slice toward memory
  // ------------------------------------------------------------
  edge_reader u_edge_reader (
    .ap_clk     (ap_clk),
    .ap_rst_n   (ap_rst_n),
    .core_rst   (core_rst),
    .start      (start),
    .base_addr  (base_addr),
    .rd         (rd_core.requester),
    .edge_valid (edge_valid),
    .edge_word  (edge_word),
    .list_done  (list_done)
  );

  read_register_slice u_read_register_slice (
    .ap_clk           (ap_clk),
    .ap_rst_n         (ap_rst_n),
    .core_rst         (core_rst),
    .core             (rd_core.memory),
    .mem_rd_req_valid (mem_rd_req_valid),
    .mem_rd_req_ready (mem_rd_req_ready),
    .mem_rd_req_addr  (mem_rd_req_addr),
    .mem_rd_rsp_valid (mem_rd_rsp_valid),
    .mem_rd_rsp_ready (mem_rd_rsp_ready),
    .mem_rd_rsp_data  (mem_rd_rsp_data)
  );

  // ------------------------------------------------------------
  // Reduction and result write
  // ------------------------------------------------------------
  vertex_reduce u_vertex_reduce (
    .ap_clk      (ap_clk),
    .ap_rst_n    (ap_rst_n),
    .core_rst    (core_rst),
    .start       (start),
    .target_vid  (target_vid),
    .edge_valid  (edge_valid),
    .edge_word   (edge_word),
    .list_done   (list_done),
    .sum_valid   (sum_valid),
    .result_word (result_word)
  );

  result_writer u_result_writer (
    .ap_clk       (ap_clk),
    .ap_rst_n     (ap_rst_n),
    .core_rst     (core_rst),
    .sum_valid    (sum_valid),
    .result_word  (result_word),
    .result_addr  (result_addr),
    .mem_wr_ready (mem_wr_ready),
    .mem_wr_ack   (mem_wr_ack),
    .mem_wr_valid (mem_wr_valid),
    .mem_wr_addr  (mem_wr_addr),
    .mem_wr_data  (mem_wr_data),
    .wr_done      (wr_done)
  );

endmodule

// ==== testbench/tb_clock_gen.sv ====
/*
 Testbench clock and reset source: 20-unit clock period,
 active-low reset held for the first four rising edges.
*/
module tb_clock_gen (
  output logic ap_clk,
  output logic ap_rst_n
);

  // Free-running clock
  initial begin
    ap_clk = 1'b0;
    forever #10 ap_clk = ~ap_clk;
  end

  // Release just after the fourth edge, like any other driven input
  initial begin
    ap_rst_n = 1'b0;
    repeat (4) @(posedge ap_clk);
    #2;
    ap_rst_n = 1'b1;
  end

endmodule

// ==== testbench/tb_kernel_afu.sv ====
/*
 Testbench for kernel_afu: word memory model with random stalls, a run
 sequence of single, empty and back-to-back lists, and concurrent checks.
*/
module tb_kernel_afu import glay_pkg::*; ();

  localparam int mem_words  = 256;
  localparam int tmo_cycles = 2000;

  logic                  ap_clk;
  logic                  ap_rst_n;
  logic                  ap_start;
  logic                  ap_idle;
  logic                  ap_done;
  logic                  ap_ready;
  logic [addr_width-1:0] buffer_0;
  logic [vid_width-1:0]  buffer_1;
  logic [addr_width-1:0] buffer_2;
  logic                  mem_rd_req_valid;
  logic                  mem_rd_req_ready;
  logic [addr_width-1:0] mem_rd_req_addr;
  logic                  mem_rd_rsp_valid;
  logic                  mem_rd_rsp_ready;
  logic [data_width-1:0] mem_rd_rsp_data;
  logic                  mem_wr_valid;
  logic                  mem_wr_ready;
  logic [addr_width-1:0] mem_wr_addr;
  logic [data_width-1:0] mem_wr_data;
  logic                  mem_wr_ack;

  logic [data_width-1:0] mem [mem_words];

  // Expected values and traffic counters for the current run
  logic [addr_width-1:0] cur_base;
  logic [31:0]           cur_n;
  logic [addr_width-1:0] exp_addr;
  logic [data_width-1:0] exp_data;
  int unsigned           rd_count;
  int unsigned           wr_count;
  logic                  ack_seen;

  int unsigned error_count;
  int unsigned timeout_count;
  int unsigned run_count;
  int unsigned r;

  tb_clock_gen u_clock_gen (
    .ap_clk   (ap_clk),
    .ap_rst_n (ap_rst_n)
  );

  kernel_afu #(
    .PULSE_HOLD (16)
  ) DUT (
    .ap_clk           (ap_clk),
    .ap_rst_n         (ap_rst_n),
    .ap_start         (ap_start),
    .ap_idle          (ap_idle),
    .ap_done          (ap_done),
    .ap_ready         (ap_ready),
    .buffer_0         (buffer_0),
    .buffer_1         (buffer_1),
    .buffer_2         (buffer_2),
    .mem_rd_req_valid (mem_rd_req_valid),
    .mem_rd_req_ready (mem_rd_req_ready),
    .mem_rd_req_addr  (mem_rd_req_addr),
    .mem_rd_rsp_valid (mem_rd_rsp_valid),
    .mem_rd_rsp_ready (mem_rd_rsp_ready),
    .mem_rd_rsp_data  (mem_rd_rsp_data),
    .mem_wr_valid     (mem_wr_valid),
    .mem_wr_ready     (mem_wr_ready),
    .mem_wr_addr      (mem_wr_addr),
    .mem_wr_data      (mem_wr_data),
    .mem_wr_ack       (mem_wr_ack)
  );

  task automatic log_failure(input string msg);
    error_count++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  task automatic log_timeout(input string what);
    timeout_count++;
    $display("Timeout at %0t: %s did not happen within %0d cycles", $time, what, tmo_cycles);
  endtask

  // ------------------------------------------------------------
  // Concurrent checks
  // ------------------------------------------------------------
  // Quiet outputs while in reset
  assert property (@(posedge ap_clk) !ap_rst_n |-> ap_idle && !ap_done && !ap_ready
                   && !DUT.start && !mem_rd_req_valid && !mem_wr_valid)
    else log_failure("outputs not at their reset values");

  // Result word and its address
  assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
                   mem_wr_valid && mem_wr_ready |-> mem_wr_addr == exp_addr)
    else log_failure("result written to the wrong address");
  assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
                   mem_wr_valid && mem_wr_ready |-> mem_wr_data == exp_data)
    else log_failure("result word differs from the expected count and weight sum");

  // Held requests stay stable under back-pressure
  assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
                   mem_rd_req_valid && !mem_rd_req_ready
                   |=> mem_rd_req_valid && $stable(mem_rd_req_addr))
    else log_failure("read request dropped or changed while stalled");
  assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
                   mem_wr_valid && !mem_wr_ready
                   |=> mem_wr_valid && $stable(mem_wr_addr) && $stable(mem_wr_data))
    else log_failure("write dropped or changed while stalled");

  // Reads stay inside header plus edge words
  assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
                   mem_rd_req_valid |-> mem_rd_req_addr >= cur_base
                   && mem_rd_req_addr <= cur_base + cur_n)
    else log_failure("read address outside the edge list");

  // Completion handshake
  assert property (@(posedge ap_clk) disable iff (!ap_rst_n) ap_done == ap_ready)
    else log_failure("ap_done and ap_ready differ");
  assert property (@(posedge ap_clk) disable iff (!ap_rst_n) ap_done |=> !ap_done)
    else log_failure("ap_done longer than one cycle");
  assert property (@(posedge ap_clk) disable iff (!ap_rst_n) ap_done |-> ack_seen && ap_idle)
    else log_failure("ap_done before write acknowledge or without ap_idle");
  assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
                   ap_done |-> rd_count == cur_n + 1 && wr_count == 1)
    else log_failure("wrong number of reads or writes in the run");
  assert property (@(posedge ap_clk) disable iff (!ap_rst_n) !ap_idle |=> !ap_idle || ap_done)
    else log_failure("ap_idle rose before ap_done");

  // ------------------------------------------------------------
  // Memory model
  // ------------------------------------------------------------
  task automatic fill_memory();
    logic [31:0] a;
    for (int i = 0; i < mem_words; i++) begin
      a = i;
      mem[i] = {~a, a ^ 32'h5a5a_5a5a};
    end
  endtask

  // Samples at the edge, drives 2 units later; responses in request order
  task automatic serve_memory();
    logic [data_width-1:0] rsp_data_q [$];
    int unsigned           rsp_due_q [$];
    int unsigned           cycle;
    int unsigned           ack_delay;
    logic                  req_fire;
    logic                  rsp_fire;
    logic                  rsp_held;
    logic                  wr_fire;
    logic [addr_width-1:0] req_addr;
    cycle     = 0;
    ack_delay = 0;
    forever begin
      @(posedge ap_clk);
      req_fire = mem_rd_req_valid && mem_rd_req_ready;
      req_addr = mem_rd_req_addr;
      rsp_fire = mem_rd_rsp_valid && mem_rd_rsp_ready;
      rsp_held = mem_rd_rsp_valid && !mem_rd_rsp_ready;
      wr_fire  = mem_wr_valid && mem_wr_ready;
      cycle++;
      if (mem_wr_ack) begin
        ack_seen = 1'b1;
      end
      if (rsp_fire) begin
        void'(rsp_data_q.pop_front());
        void'(rsp_due_q.pop_front());
      end
      if (req_fire) begin
        rd_count++;
        rsp_data_q.push_back(mem[req_addr % mem_words]);
        rsp_due_q.push_back(cycle + $urandom_range(3));
      end
      if (wr_fire) begin
        wr_count++;
        mem[mem_wr_addr % mem_words] = mem_wr_data;
        ack_delay = 1 + $urandom_range(2);
      end
      #2;
      mem_rd_req_ready = ($urandom_range(3) != 0);
      mem_wr_ready     = ($urandom_range(1) == 1);
      // Ack pulse a few cycles after the write transfer
      mem_wr_ack = 1'b0;
      if (ack_delay != 0) begin
        ack_delay--;
        if (ack_delay == 0) begin
          mem_wr_ack = 1'b1;
        end
      end
      // A stalled response keeps its valid and data
      if (!rsp_held) begin
        mem_rd_rsp_valid = 1'b0;
        if (rsp_data_q.size() > 0 && rsp_due_q[0] <= cycle && $urandom_range(3) != 0) begin
          mem_rd_rsp_valid = 1'b1;
          mem_rd_rsp_data  = rsp_data_q[0];
        end
      end
    end
  endtask

  // ------------------------------------------------------------
  // Run setup and waits
  // ------------------------------------------------------------
  // Header at base, edges after it; expected result from the list itself
  task automatic load_list(input logic [addr_width-1:0] base, input int unsigned n,
                           input logic [addr_width-1:0] res);
    mem_word_u            word;
    logic [vid_width-1:0] target;
    logic [31:0]          cnt;
    logic [31:0]          sum;
    int unsigned          i;
    target = 32'd100 + $urandom_range(49);
    cnt    = '0;
    sum    = '0;
    word.header.reserved  = $urandom;
    word.header.num_edges = n;
    mem[base] = word;
    for (i = 1; i <= n; i++) begin
      // Destinations near the target, so roughly one in four matches
      word.edge_rec.dst_id = target - 1 + $urandom_range(3);
      word.edge_rec.weight = $urandom;
      if (word.edge_rec.dst_id == target) begin
        cnt = cnt + 1;
        sum = sum + word.edge_rec.weight;
      end
      mem[base + i] = word;
    end
    buffer_0 = base;
    buffer_1 = target;
    buffer_2 = res;
    cur_base = base;
    cur_n    = n;
    exp_addr = res;
    exp_data = {cnt, sum};
    rd_count = 0;
    wr_count = 0;
    ack_seen = 1'b0;
  endtask

  task automatic wait_reset_release();
    int unsigned k;
    for (k = 0; k < tmo_cycles; k++) begin
      @(posedge ap_clk);
      if (ap_rst_n) break;
    end
    if (k == tmo_cycles) log_timeout("reset release");
    #2;
  endtask

  task automatic wait_accept();
    int unsigned k;
    for (k = 0; k < tmo_cycles; k++) begin
      @(posedge ap_clk);
      if (!ap_idle) break;
    end
    if (k == tmo_cycles) log_timeout("run acceptance");
    #2;
  endtask

  task automatic wait_done();
    int unsigned k;
    for (k = 0; k < tmo_cycles; k++) begin
      @(posedge ap_clk);
      if (ap_done) break;
    end
    if (k == tmo_cycles) begin
      log_timeout("ap_done");
    end else begin
      run_count++;
    end
    #2;
  endtask

  // Start held until accepted, then dropped
  task automatic run_single();
    ap_start = 1'b1;
    wait_accept();
    ap_start = 1'b0;
    wait_done();
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    ap_start         = 1'b0;
    buffer_0         = '0;
    buffer_1         = '0;
    buffer_2         = '0;
    mem_rd_req_ready = 1'b0;
    mem_rd_rsp_valid = 1'b0;
    mem_rd_rsp_data  = '0;
    mem_wr_ready     = 1'b0;
    mem_wr_ack       = 1'b0;
    cur_base         = '0;
    cur_n            = '0;
    exp_addr         = '0;
    exp_data         = '0;
    rd_count         = 0;
    wr_count         = 0;
    ack_seen         = 1'b0;
    error_count      = 0;
    timeout_count    = 0;
    run_count        = 0;
    void'($urandom(32'h996d7f74));
    fill_memory();
    fork
      serve_memory();
    join_none
    wait_reset_release();
    // Random list, then an empty one
    load_list(32'd8, 12, 32'd240);
    run_single();
    load_list(32'd40, 0, 32'd241);
    run_single();
    // Back-to-back runs, next descriptor loaded during the reset hold
    ap_start = 1'b1;
    for (r = 0; r < 4; r++) begin
      load_list(32'd60 + $urandom_range(100), 1 + $urandom_range(29), 32'd200 + r);
      wait_accept();
      wait_done();
    end
    ap_start = 1'b0;
    repeat (5) @(posedge ap_clk);
    $display("Summary: runs=%0d errors=%0d timeouts=%0d", run_count, error_count,
             timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== glay_kernel.f ====
hdl/glay_pkg.sv
hdl/mem_read_if.sv
hdl/kernel_control.sv
hdl/read_register_slice.sv
hdl/edge_reader.sv
hdl/vertex_reduce.sv
hdl/result_writer.sv
hdl/kernel_afu.sv
testbench/tb_clock_gen.sv
testbench/tb_kernel_afu.sv

// ==== Bender.yml ====
package:
  name: glay_kernel

sources:
  - hdl/glay_pkg.sv
  - hdl/mem_read_if.sv
  - hdl/kernel_control.sv
  - hdl/read_register_slice.sv
  - hdl/edge_reader.sv
  - hdl/vertex_reduce.sv
  - hdl/result_writer.sv
  - hdl/kernel_afu.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_kernel_afu.sv
